//--- Bender.yml
package:
  name: singleCpu

sources:
  - files:
      - hdl/rvIsaPkg.sv
      - hdl/cpuCtrlPkg.sv
      - hdl/dataMemIf.sv
      - hdl/controlDecode.sv
      - hdl/regFile.sv
      - hdl/aluUnit.sv
      - hdl/dataMem.sv
      - hdl/singleCpu.sv
  - target: test
    files:
      - dv/singleCpu_asserts.sv
      - dv/tbSingleCpu.sv

//--- dv/singleCpu_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module singleCpu_asserts
    import rvIsaPkg::*;
(
    input logic            CLK,
    input logic            rst,
    input logic [XLEN-1:0] instAddr,
    input logic            regWe,
    input logic [XLEN-1:0] curInst
);

    int failCount = 0; // Polled by the testbench

    // No register write while in reset
    resetNoWrite: assert property (@(posedge CLK) rst |-> !regWe)
        else begin
            failCount++;
            $error("regWe is high while rst is high");
        end

    // First fetch after reset from address 0
    resetPcZero: assert property (@(posedge CLK) $fell(rst) |-> instAddr == '0)
        else begin
            failCount++;
            $error("instAddr is not 0 in the cycle after reset");
        end

    // Sequential fetch for everything except beq
    pcAdvance: assert property (@(posedge CLK) disable iff (rst)
        (!rst && curInst[6:0] != opBranch) |=> (instAddr == $past(instAddr) + XLEN'(4)))
        else begin
            failCount++;
            $error("instAddr did not advance by 4 after a non-branch instruction");
        end

endmodule

`default_nettype wire

//--- dv/tbSingleCpu.sv
`timescale 1ns/10ps
`default_nettype none

module tbSingleCpu
    import rvIsaPkg::*;
();

    localparam int ROM_WORDS = 64;

    logic        CLK;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] instAddr;
    logic        regWe;
    logic [4:0]  regWaddr;
    logic [31:0] regWdata;
    logic [31:0] curInst;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] mRegs [32]; // Architectural model
    logic [31:0] mMem [64];
    logic [31:0] mPc;
    int          progLen;
    int          cycleCount;
    int          cycleLimit;
    logic        progDone;

    singleCpu UUT (
        .CLK      (CLK),
        .rst      (rst),
        .inst     (inst),
        .instAddr (instAddr),
        .regWe    (regWe),
        .regWaddr (regWaddr),
        .regWdata (regWdata),
        .curInst  (curInst)
    );

    bind singleCpu singleCpu_asserts assertInst (
        .CLK      (CLK),
        .rst      (rst),
        .instAddr (instAddr),
        .regWe    (regWe),
        .curInst  (curInst)
    );

    assign inst = rom[instAddr[7:2]]; // Instruction ROM read in the same cycle

    always #50 CLK = ~CLK;

    task automatic stopOnFailure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] gotVal);
        stopOnFailure($sformatf("Error %s expected %h got %h", name, expVal, gotVal));
    endtask

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd, input opcodeT op);
        return {imm, rs1, (op == opLoad) ? F3Word : F3Add, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3Word, imm[4:0], opStore};
    endfunction

    // Offset in bytes with bit 0 dropped by the format
    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {off[12], off[10:5], rs2, rs1, F3Beq, off[4:1], off[11], opBranch};
    endfunction

    task automatic addInstr(input logic [31:0] word);
        rom[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [11:0] off;
        logic [4:0]  src;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;
        end
        progLen = 0;
        for (int k = 1; k <= 8; k++) begin
            // x8 always gets a negative immediate
            addInstr(encI((k == 8) ? (12'($urandom) | 12'h800) : 12'($urandom),
                          5'd0, 5'(k), opImm));
        end
        for (int i = 0; i < 15; i++) begin
            case (i % 5)
                0: addInstr(encR(7'h00, 5'(1 + $urandom % 8), 5'(1 + $urandom % 8), F3Add,
                                 5'(1 + $urandom % 13)));
                1: addInstr(encR(7'h20, 5'(1 + $urandom % 8), 5'(1 + $urandom % 8), F3Add,
                                 5'(1 + $urandom % 13)));
                2: addInstr(encR(7'h00, 5'(1 + $urandom % 8), 5'(1 + $urandom % 8), F3And,
                                 5'(1 + $urandom % 13)));
                3: addInstr(encR(7'h00, 5'(1 + $urandom % 8), 5'(1 + $urandom % 8), F3Or,
                                 5'(1 + $urandom % 13)));
                default: addInstr(encR(7'h00, 5'(1 + $urandom % 8), 5'(1 + $urandom % 8),
                                       F3Slt, 5'(1 + $urandom % 13)));
            endcase
        end
        for (int p = 0; p < 3; p++) begin
            off = 12'(($urandom % 64) * 4);
            src = 5'(1 + $urandom % 8);
            addInstr(encS(off, src, 5'd0));
            addInstr(encI(off, 5'd0, 5'(14 + p), opLoad));
        end
        addInstr(encI(12'd5, 5'd0, 5'd9, opImm));
        addInstr(encI(12'hff0, 5'd0, 5'd17, opImm));       // x17 is -16
        addInstr(encR(7'h00, 5'd9, 5'd17, F3Slt, 5'd18));  // Signed -16 < 5
        addInstr(encB(13'd8, 5'd9, 5'd0));           // Not taken as x9 is 5
        addInstr(encR(7'h00, 5'd2, 5'd1, F3Add, 5'd10));
        addInstr(encB(13'd8, 5'd1, 5'd1));           // Always taken
        addInstr(encI(12'd99, 5'd0, 5'd11, opImm));  // Skipped
        addInstr(encI(12'd123, 5'd0, 5'd0, opImm));
        addInstr(encR(7'h00, 5'd2, 5'd1, F3Add, 5'd0));
        addInstr(encR(7'h00, 5'd3, 5'd0, F3Add, 5'd12));
        addInstr(encR(7'h00, 5'd0, 5'd4, F3Add, 5'd13));
    endtask

    // Model step and compare at the falling edge where outputs are settled
    always @(negedge CLK) begin : modelStep
        logic [31:0] instr;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] expData;
        logic [31:0] expNext;
        logic        expWe;
        if (rst) begin
            assert (regWe === 1'b0) else reportMismatch("regWe", 32'd0, 32'(regWe));
            assert (instAddr === '0) else reportMismatch("instAddr", 32'd0, instAddr);
            mPc = '0;
            for (int i = 0; i < 32; i++) begin
                mRegs[i] = '0;
            end
        end else if (!progDone) begin
            cycleCount++;
            instr = rom[mPc[7:2]];
            opA = mRegs[instr[19:15]];
            opB = mRegs[instr[24:20]];
            immI = {{20{instr[31]}}, instr[31:20]};
            immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            expWe = 1'b0;
            expData = '0;
            expNext = mPc + 32'd4;
            case (instr[6:0])
                opReg: begin
                    expWe = 1'b1;
                    case (instr[14:12])
                        F3Add: expData = instr[30] ? opA - opB : opA + opB;
                        F3Slt: expData = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
                        F3Or: expData = opA | opB;
                        default: expData = opA & opB;
                    endcase
                end
                opImm: begin
                    expWe = 1'b1;
                    expData = opA + immI;
                end
                opLoad: begin
                    expWe = 1'b1;
                    expData = mMem[(opA + immI) >> 2 & 32'h3f];
                end
                opStore: mMem[(opA + immS) >> 2 & 32'h3f] = opB;
                opBranch: if (opA == opB) expNext = mPc + immB;
                default: ;
            endcase
            assert (instAddr === mPc) else reportMismatch("instAddr", mPc, instAddr);
            assert (curInst === instr) else reportMismatch("curInst", instr, curInst);
            assert (regWe === expWe) else reportMismatch("regWe", 32'(expWe), 32'(regWe));
            assert (regWaddr === instr[11:7])
                else reportMismatch("regWaddr", 32'(instr[11:7]), 32'(regWaddr));
            if (expWe) begin
                assert (regWdata === expData) else reportMismatch("regWdata", expData, regWdata);
            end
            assert (UUT.assertInst.failCount == 0)
                else stopOnFailure("A bound assertion on the processor failed");
            if (expWe && instr[11:7] != 5'd0) begin
                mRegs[instr[11:7]] = expData;
            end
            mPc = expNext;
            if (mPc >= 32'(progLen * 4)) begin
                progDone = 1'b1;
            end
        end
    end

    initial begin
        CLK = 1'b0;
        rst = 1'b1;
        progDone = 1'b0;
        cycleCount = 0;
        void'($urandom(32'h78384585));
        buildProgram();
        cycleLimit = 2 * progLen + 20;
        repeat (8) @(posedge CLK);
        rst <= 1'b0;
        wait (progDone || cycleCount >= cycleLimit);
        if (progDone) begin
            $display("All checks passed");
            $finish;
        end else begin
            stopOnFailure($sformatf("Timeout after %0d cycles before the program ended",
                                    cycleCount));
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
hdl/rvIsaPkg.sv
hdl/cpuCtrlPkg.sv
hdl/dataMemIf.sv
hdl/controlDecode.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/dataMem.sv
hdl/singleCpu.sv
dv/singleCpu_asserts.sv
dv/tbSingleCpu.sv

//--- hdl/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  aluOpT           op,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    always_comb begin
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluSlt: result = ($signed(a) < $signed(b)) ? XLEN'(1) : '0; // Signed compare
            default: result = '0;
        endcase
    end

    // Drives the beq decision
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hdl/controlDecode.sv
`timescale 1ns/10ps
`default_nettype none

module controlDecode
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic [XLEN-1:0] instr,
    output ctrlT            ctrl,
    output logic [XLEN-1:0] imm
);

    opcodeT              opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic                funct7b5;

    assign opcode   = opcodeT'(instr[OPCODE_W-1:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30]; // Selects sub for R-type

    // Main and ALU control
    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluOp    = aluAdd;
        case (opcode)
            opReg, opImm: begin
                ctrl.aluSrc = (opcode == opImm);
                ctrl.regWrite = 1'b1;
                case (funct3)
                    F3Add: begin
                        // Bit 30 only means sub for register operands
                        if (opcode == opReg && funct7b5) begin
                            ctrl.aluOp = aluSub;
                        end else begin
                            ctrl.aluOp = aluAdd;
                        end
                    end
                    F3Slt: ctrl.aluOp = aluSlt;
                    F3Or:  ctrl.aluOp = aluOr;
                    F3And: ctrl.aluOp = aluAnd;
                    default: ctrl.regWrite = 1'b0; // Not in the subset
                endcase
            end
            opLoad: begin
                ctrl.regWrite = (funct3 == F3Word);
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            opStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = (funct3 == F3Word);
            end
            opBranch: begin
                ctrl.branch = (funct3 == F3Beq);
                ctrl.aluOp  = aluSub; // Equal when difference is zero
            end
            default: ;
        endcase
    end

    // Immediate generation, sign taken from bit 31
    always_comb begin
        case (opcode)
            opStore: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offset kept in halfwords, scaled at the PC adder
            opBranch: imm = {{20{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8]};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;

    // Operations the ALU can carry out
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    // Control word from the decoder to the datapath
    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;   // Immediate as second operand
        logic  memWrite;
        logic  memToReg; // Load data to rd
        logic  branch;
        aluOpT aluOp;
    } ctrlT;

    // Data memory size in words
    localparam int DMEM_ADDR_W = 6;
    localparam int DMEM_WORDS  = 1 << DMEM_ADDR_W;

endpackage

`default_nettype wire

//--- hdl/dataMem.sv
`timescale 1ns/10ps
`default_nettype none

module dataMem
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic CLK,
    dataMemIf.mem bus
);

    logic [XLEN-1:0]        mem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] wordAddr;

    // Word index from byte address bits 7:2
    assign wordAddr = bus.addr[DMEM_ADDR_W+1:2];

    always_ff @(posedge CLK) begin
        if (bus.we) begin
            mem[wordAddr] <= bus.wdata;
        end
    end

    // Read data follows the address in the same cycle
    assign bus.rdata = mem[wordAddr];

endmodule

`default_nettype wire

//--- hdl/dataMemIf.sv
`timescale 1ns/10ps
`default_nettype none

interface dataMemIf import rvIsaPkg::*; ();

    logic [XLEN-1:0] addr;  // Byte address from the ALU
    logic [XLEN-1:0] wdata;
    logic            we;
    logic [XLEN-1:0] rdata;

    // Processor side
    modport cpu (output addr, output wdata, output we, input rdata);

    // Memory side
    modport mem (input addr, input wdata, input we, output rdata);

endinterface

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile
    import rvIsaPkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [XLEN-1:0]       wdata,
    input  logic                  we,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2
);

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin // x0 writes dropped
            regs[rd] <= wdata;
        end
    end

    // Asynchronous reads
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- hdl/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // Basic widths of the RV32I subset
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;

    // Major opcodes, instr[6:0]
    typedef enum logic [OPCODE_W-1:0] {
        opReg    = 7'b0110011, // add sub and or slt
        opImm    = 7'b0010011, // addi
        opLoad   = 7'b0000011, // lw
        opStore  = 7'b0100011, // sw
        opBranch = 7'b1100011  // beq
    } opcodeT;

    // funct3 values, instr[14:12]
    localparam logic [FUNCT3_W-1:0] F3Add  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3Slt  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3Or   = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3And  = 3'b111;
    localparam logic [FUNCT3_W-1:0] F3Word = 3'b010; // lw and sw
    localparam logic [FUNCT3_W-1:0] F3Beq  = 3'b000;

endpackage

`default_nettype wire

//--- hdl/singleCpu.sv
`timescale 1ns/10ps
`default_nettype none

module singleCpu
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    input  logic [XLEN-1:0]       inst,     // From instruction memory
    output logic [XLEN-1:0]       instAddr, // Fetch address
    output logic                  regWe,
    output logic [REG_ADDR_W-1:0] regWaddr,
    output logic [XLEN-1:0]       regWdata,
    output logic [XLEN-1:0]       curInst
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] nextPc;
    ctrlT            ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResult;
    logic            aluZero;
    logic            takeBranch;

    dataMemIf dmBus ();

    // PC register
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // beq taken when rs1 - rs2 is zero
    assign takeBranch = ctrl.branch & aluZero;
    assign nextPc     = takeBranch ? pc + (imm << 1) : pc + XLEN'(4);

    controlDecode decodeInst (
        .instr (inst),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    regFile regFileInst (
        .CLK    (CLK),
        .rst    (rst),
        .rs1    (inst[19:15]),
        .rs2    (inst[24:20]),
        .rd     (regWaddr),
        .wdata  (regWdata),
        .we     (regWe),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign aluB = ctrl.aluSrc ? imm : rdata2; // Second operand

    aluUnit aluInst (
        .a      (rdata1),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    // Memory side of the datapath
    assign dmBus.addr  = aluResult;
    assign dmBus.wdata = rdata2;
    assign dmBus.we    = ctrl.memWrite & ~rst;

    dataMem dataMemInst (
        .CLK (CLK),
        .bus (dmBus.mem)
    );

    // Write-back
    assign regWe    = ctrl.regWrite & ~rst;
    assign regWaddr = inst[11:7];
    assign regWdata = ctrl.memToReg ? dmBus.rdata : aluResult;

    assign instAddr = pc;
    assign curInst  = inst;

endmodule

`default_nettype wire
